// ==== source/mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

  // byte address
  typedef logic [31:0] addr_t;

  // bus and register data
  typedef logic [63:0] data_t;

  // one strobe per data byte
  typedef logic [7:0] strb_t;

  typedef logic [1:0] resp_t;

  localparam resp_t resp_okay   = 2'd0;
  localparam resp_t resp_slverr = 2'd2;

  // size letter plus optional zero extension on reads
  typedef enum logic [2:0] {
    acc_b,
    acc_bu,
    acc_h,
    acc_hu,
    acc_w,
    acc_wu,
    acc_d
  } access_e;

  typedef enum logic [2:0] {
    st_idle,
    st_write,
    st_wresp,
    st_read,
    st_rresp
  } bridge_state_e;

endpackage

`default_nettype wire

// ==== source/mem_access_bridge.sv ====
`default_nettype none

module mem_access_bridge (
  input  wire                       clk,
  input  wire                       rst,
  // request port
  input  wire                       req_valid_i,
  output logic                      req_ready_o,
  input  wire                       req_we_i,
  input  wire mem_bus_pkg::addr_t   req_addr_i,
  input  wire mem_bus_pkg::access_e req_type_i,
  input  wire mem_bus_pkg::data_t   req_wdata_i,
  output logic                      resp_valid_o,
  output mem_bus_pkg::data_t        resp_data_o,
  output logic                      resp_err_o,
  // axi master side
  output logic                      aw_valid_o,
  input  wire                       aw_ready_i,
  output mem_bus_pkg::addr_t        aw_addr_o,
  output logic                      w_valid_o,
  input  wire                       w_ready_i,
  output mem_bus_pkg::data_t        w_data_o,
  output mem_bus_pkg::strb_t        w_strb_o,
  input  wire                       b_valid_i,
  output logic                      b_ready_o,
  input  wire mem_bus_pkg::resp_t   b_resp_i,
  output logic                      ar_valid_o,
  input  wire                       ar_ready_i,
  output mem_bus_pkg::addr_t        ar_addr_o,
  input  wire                       r_valid_i,
  output logic                      r_ready_o,
  input  wire mem_bus_pkg::data_t   r_data_i,
  input  wire mem_bus_pkg::resp_t   r_resp_i
);
  import mem_bus_pkg::*;

  bridge_state_e state_q;
  logic          aw_pend_q;
  logic          w_pend_q;
  addr_t         addr_q;
  access_e       type_q;
  data_t         wdata_q;
  logic [5:0]    lane_shift;
  data_t         r_shifted;
  data_t         r_formatted;
  strb_t         req_mask;

  // bytes touched by an access sitting in lane 0
  function automatic strb_t size_mask(access_e t);
    case (t)
      acc_b, acc_bu: return 8'h01;
      acc_h, acc_hu: return 8'h03;
      acc_w, acc_wu: return 8'h0f;
      default:       return 8'hff;
    endcase
  endfunction

  assign lane_shift = {addr_q[2:0], 3'b000};
  assign req_mask   = size_mask(req_type_i);

  assign req_ready_o = (state_q == st_idle);
  assign aw_valid_o  = aw_pend_q;
  assign w_valid_o   = w_pend_q;
  assign aw_addr_o   = addr_q;
  assign ar_addr_o   = addr_q;
  assign w_data_o    = wdata_q << lane_shift;
  assign w_strb_o    = size_mask(type_q) << addr_q[2:0];
  assign b_ready_o   = (state_q == st_wresp);
  assign ar_valid_o  = (state_q == st_read);
  assign r_ready_o   = (state_q == st_rresp);

  // load formatting, byte lane down to bit 0 then extend
  always_comb begin
    r_shifted = r_data_i >> lane_shift;
    case (type_q)
      acc_b:   r_formatted = {{56{r_shifted[7]}}, r_shifted[7:0]};
      acc_bu:  r_formatted = {56'd0, r_shifted[7:0]};
      acc_h:   r_formatted = {{48{r_shifted[15]}}, r_shifted[15:0]};
      acc_hu:  r_formatted = {48'd0, r_shifted[15:0]};
      acc_w:   r_formatted = {{32{r_shifted[31]}}, r_shifted[31:0]};
      acc_wu:  r_formatted = {32'd0, r_shifted[31:0]};
      default: r_formatted = r_shifted;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= st_idle;
      aw_pend_q    <= 1'b0;
      w_pend_q     <= 1'b0;
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= 1'b0;
      case (state_q)
        st_idle: begin
          if (req_valid_i) begin
            state_q   <= req_we_i ? st_write : st_read;
            aw_pend_q <= req_we_i;
            w_pend_q  <= req_we_i;
          end
        end
        st_write: begin
          // address and data may be taken in different cycles
          if (aw_ready_i) begin
            aw_pend_q <= 1'b0;
          end
          if (w_ready_i) begin
            w_pend_q <= 1'b0;
          end
          if ((!aw_pend_q || aw_ready_i) && (!w_pend_q || w_ready_i)) begin
            state_q <= st_wresp;
          end
        end
        st_wresp: begin
          if (b_valid_i) begin
            state_q      <= st_idle;
            resp_valid_o <= 1'b1;
          end
        end
        st_read: begin
          if (ar_ready_i) begin
            state_q <= st_rresp;
          end
        end
        st_rresp: begin
          if (r_valid_i) begin
            state_q      <= st_idle;
            resp_valid_o <= 1'b1;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i && req_ready_o) begin
      addr_q  <= req_addr_i;
      type_q  <= req_type_i;
      wdata_q <= req_wdata_i;
    end
    if (b_valid_i && b_ready_o) begin
      resp_data_o <= '0;
      resp_err_o  <= (b_resp_i != resp_okay);
    end
    if (r_valid_i && r_ready_o) begin
      resp_data_o <= r_formatted;
      resp_err_o  <= (r_resp_i != resp_okay);
    end
  end

  // offset bits below the access size must be zero
  a_req_aligned: assert property (@(posedge clk) disable iff (rst)
    req_valid_i && req_ready_o
      |-> (req_addr_i[2:0] & {req_mask[4], req_mask[2], req_mask[1]}) == 3'b000);

  a_aw_ar_excl: assert property (@(posedge clk) disable iff (rst)
    !(aw_valid_o && ar_valid_o));

endmodule

`default_nettype wire

// ==== source/bus_arbiter.sv ====
`default_nettype none

module bus_arbiter (
  input  wire                     clk,
  input  wire                     rst,
  // master 0, ifu bridge
  input  wire                     m0_aw_valid_i,
  output logic                    m0_aw_ready_o,
  input  wire mem_bus_pkg::addr_t m0_aw_addr_i,
  input  wire                     m0_w_valid_i,
  output logic                    m0_w_ready_o,
  input  wire mem_bus_pkg::data_t m0_w_data_i,
  input  wire mem_bus_pkg::strb_t m0_w_strb_i,
  output logic                    m0_b_valid_o,
  input  wire                     m0_b_ready_i,
  output mem_bus_pkg::resp_t      m0_b_resp_o,
  input  wire                     m0_ar_valid_i,
  output logic                    m0_ar_ready_o,
  input  wire mem_bus_pkg::addr_t m0_ar_addr_i,
  output logic                    m0_r_valid_o,
  input  wire                     m0_r_ready_i,
  output mem_bus_pkg::data_t      m0_r_data_o,
  output mem_bus_pkg::resp_t      m0_r_resp_o,
  // master 1, lsu bridge
  input  wire                     m1_aw_valid_i,
  output logic                    m1_aw_ready_o,
  input  wire mem_bus_pkg::addr_t m1_aw_addr_i,
  input  wire                     m1_w_valid_i,
  output logic                    m1_w_ready_o,
  input  wire mem_bus_pkg::data_t m1_w_data_i,
  input  wire mem_bus_pkg::strb_t m1_w_strb_i,
  output logic                    m1_b_valid_o,
  input  wire                     m1_b_ready_i,
  output mem_bus_pkg::resp_t      m1_b_resp_o,
  input  wire                     m1_ar_valid_i,
  output logic                    m1_ar_ready_o,
  input  wire mem_bus_pkg::addr_t m1_ar_addr_i,
  output logic                    m1_r_valid_o,
  input  wire                     m1_r_ready_i,
  output mem_bus_pkg::data_t      m1_r_data_o,
  output mem_bus_pkg::resp_t      m1_r_resp_o,
  // slave side
  output logic                    s_aw_valid_o,
  input  wire                     s_aw_ready_i,
  output mem_bus_pkg::addr_t      s_aw_addr_o,
  output logic                    s_w_valid_o,
  input  wire                     s_w_ready_i,
  output mem_bus_pkg::data_t      s_w_data_o,
  output mem_bus_pkg::strb_t      s_w_strb_o,
  input  wire                     s_b_valid_i,
  output logic                    s_b_ready_o,
  input  wire mem_bus_pkg::resp_t s_b_resp_i,
  output logic                    s_ar_valid_o,
  input  wire                     s_ar_ready_i,
  output mem_bus_pkg::addr_t      s_ar_addr_o,
  input  wire                     s_r_valid_i,
  output logic                    s_r_ready_o,
  input  wire mem_bus_pkg::data_t s_r_data_i,
  input  wire mem_bus_pkg::resp_t s_r_resp_i
);

  logic busy_q;
  // 1 selects lsu
  logic grant_q;
  logic sel_m0;
  logic sel_m1;
  logic m0_req;
  logic m1_req;
  logic xfer_done;

  assign sel_m0    = busy_q && !grant_q;
  assign sel_m1    = busy_q && grant_q;
  assign m0_req    = m0_aw_valid_i || m0_ar_valid_i;
  assign m1_req    = m1_aw_valid_i || m1_ar_valid_i;
  assign xfer_done = (s_b_valid_i && s_b_ready_o) || (s_r_valid_i && s_r_ready_o);

  // grant lasts until the response beat, lsu wins a tie
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q  <= 1'b0;
      grant_q <= 1'b0;
    end else if (busy_q) begin
      if (xfer_done) begin
        busy_q <= 1'b0;
      end
    end else if (m0_req || m1_req) begin
      busy_q  <= 1'b1;
      grant_q <= m1_req;
    end
  end

  // towards the slave
  assign s_aw_valid_o = (sel_m0 && m0_aw_valid_i) || (sel_m1 && m1_aw_valid_i);
  assign s_aw_addr_o  = grant_q ? m1_aw_addr_i : m0_aw_addr_i;
  assign s_w_valid_o  = (sel_m0 && m0_w_valid_i) || (sel_m1 && m1_w_valid_i);
  assign s_w_data_o   = grant_q ? m1_w_data_i : m0_w_data_i;
  assign s_w_strb_o   = grant_q ? m1_w_strb_i : m0_w_strb_i;
  assign s_b_ready_o  = (sel_m0 && m0_b_ready_i) || (sel_m1 && m1_b_ready_i);
  assign s_ar_valid_o = (sel_m0 && m0_ar_valid_i) || (sel_m1 && m1_ar_valid_i);
  assign s_ar_addr_o  = grant_q ? m1_ar_addr_i : m0_ar_addr_i;
  assign s_r_ready_o  = (sel_m0 && m0_r_ready_i) || (sel_m1 && m1_r_ready_i);

  // back to the masters, payloads are shared
  assign m0_aw_ready_o = sel_m0 && s_aw_ready_i;
  assign m0_w_ready_o  = sel_m0 && s_w_ready_i;
  assign m0_b_valid_o  = sel_m0 && s_b_valid_i;
  assign m0_ar_ready_o = sel_m0 && s_ar_ready_i;
  assign m0_r_valid_o  = sel_m0 && s_r_valid_i;
  assign m1_aw_ready_o = sel_m1 && s_aw_ready_i;
  assign m1_w_ready_o  = sel_m1 && s_w_ready_i;
  assign m1_b_valid_o  = sel_m1 && s_b_valid_i;
  assign m1_ar_ready_o = sel_m1 && s_ar_ready_i;
  assign m1_r_valid_o  = sel_m1 && s_r_valid_i;
  assign m0_b_resp_o   = s_b_resp_i;
  assign m1_b_resp_o   = s_b_resp_i;
  assign m0_r_data_o   = s_r_data_i;
  assign m1_r_data_o   = s_r_data_i;
  assign m0_r_resp_o   = s_r_resp_i;
  assign m1_r_resp_o   = s_r_resp_i;

  a_grant_held: assert property (@(posedge clk) disable iff (rst)
    busy_q |=> $stable(grant_q));

endmodule

`default_nettype wire

// ==== source/axi_mem_slave.sv ====
`default_nettype none

module axi_mem_slave #(
  parameter int unsigned mem_words = 256
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     aw_valid_i,
  output logic                    aw_ready_o,
  input  wire mem_bus_pkg::addr_t aw_addr_i,
  input  wire                     w_valid_i,
  output logic                    w_ready_o,
  input  wire mem_bus_pkg::data_t w_data_i,
  input  wire mem_bus_pkg::strb_t w_strb_i,
  output logic                    b_valid_o,
  input  wire                     b_ready_i,
  output mem_bus_pkg::resp_t      b_resp_o,
  input  wire                     ar_valid_i,
  output logic                    ar_ready_o,
  input  wire mem_bus_pkg::addr_t ar_addr_i,
  output logic                    r_valid_o,
  input  wire                     r_ready_i,
  output mem_bus_pkg::data_t      r_data_o,
  output mem_bus_pkg::resp_t      r_resp_o
);
  import mem_bus_pkg::*;

  localparam int unsigned idx_w = $clog2(mem_words);
  localparam addr_t mem_bytes = addr_t'(mem_words * 8);

  data_t            mem [mem_words];
  logic             init_q;
  logic [idx_w-1:0] init_idx_q;
  logic             pending;
  logic             wr_fire;
  logic             rd_fire;
  logic             wr_in_range;
  logic             rd_in_range;
  logic [idx_w-1:0] wr_idx;
  logic [idx_w-1:0] rd_idx;

  assign pending    = b_valid_o || r_valid_o;
  // address and data are taken together in one beat
  assign aw_ready_o = !init_q && !pending && aw_valid_i && w_valid_i;
  assign w_ready_o  = aw_ready_o;
  assign ar_ready_o = !init_q && !pending;

  assign wr_fire     = aw_valid_i && aw_ready_o;
  assign rd_fire     = ar_valid_i && ar_ready_o;
  assign wr_in_range = (aw_addr_i < mem_bytes);
  assign rd_in_range = (ar_addr_i < mem_bytes);
  assign wr_idx      = aw_addr_i[idx_w+2:3];
  assign rd_idx      = ar_addr_i[idx_w+2:3];

  always_ff @(posedge clk) begin
    if (rst) begin
      init_q     <= 1'b1;
      init_idx_q <= '0;
      b_valid_o  <= 1'b0;
      r_valid_o  <= 1'b0;
    end else begin
      if (init_q) begin
        init_idx_q <= init_idx_q + 1'b1;
        if (init_idx_q == idx_w'(mem_words - 1)) begin
          init_q <= 1'b0;
        end
      end
      if (wr_fire) begin
        b_valid_o <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_o <= 1'b0;
      end
      if (rd_fire) begin
        r_valid_o <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_o <= 1'b0;
      end
    end
  end

  // clear one word per cycle after reset, then byte writes
  always_ff @(posedge clk) begin
    if (init_q) begin
      mem[init_idx_q] <= '0;
    end else if (wr_fire && wr_in_range) begin
      for (int i = 0; i < 8; i++) begin
        if (w_strb_i[i]) begin
          mem[wr_idx][8*i +: 8] <= w_data_i[8*i +: 8];
        end
      end
    end
    if (wr_fire) begin
      b_resp_o <= wr_in_range ? resp_okay : resp_slverr;
    end
    if (rd_fire) begin
      r_data_o <= rd_in_range ? mem[rd_idx] : '0;
      r_resp_o <= rd_in_range ? resp_okay : resp_slverr;
    end
  end

  // relies on the arbiter never passing aw and ar at once
  a_one_resp: assert property (@(posedge clk) disable iff (rst)
    !(b_valid_o && r_valid_o));

endmodule

`default_nettype wire

// ==== source/mem_bus_top.sv ====
`default_nettype none

module mem_bus_top #(
  parameter int unsigned mem_words = 256
) (
  input  wire                       clk,
  input  wire                       rst,
  // ifu port
  input  wire                       ifu_req_valid_i,
  output logic                      ifu_req_ready_o,
  input  wire                       ifu_req_we_i,
  input  wire mem_bus_pkg::addr_t   ifu_req_addr_i,
  input  wire mem_bus_pkg::access_e ifu_req_type_i,
  input  wire mem_bus_pkg::data_t   ifu_req_wdata_i,
  output logic                      ifu_resp_valid_o,
  output mem_bus_pkg::data_t        ifu_resp_data_o,
  output logic                      ifu_resp_err_o,
  // lsu port
  input  wire                       lsu_req_valid_i,
  output logic                      lsu_req_ready_o,
  input  wire                       lsu_req_we_i,
  input  wire mem_bus_pkg::addr_t   lsu_req_addr_i,
  input  wire mem_bus_pkg::access_e lsu_req_type_i,
  input  wire mem_bus_pkg::data_t   lsu_req_wdata_i,
  output logic                      lsu_resp_valid_o,
  output mem_bus_pkg::data_t        lsu_resp_data_o,
  output logic                      lsu_resp_err_o
);
  import mem_bus_pkg::*;

  // ifu bridge to arbiter
  logic  ifu_aw_valid, ifu_aw_ready, ifu_w_valid, ifu_w_ready;
  logic  ifu_b_valid, ifu_b_ready, ifu_ar_valid, ifu_ar_ready, ifu_r_valid, ifu_r_ready;
  addr_t ifu_aw_addr, ifu_ar_addr;
  data_t ifu_w_data, ifu_r_data;
  strb_t ifu_w_strb;
  resp_t ifu_b_resp, ifu_r_resp;

  // lsu bridge to arbiter
  logic  lsu_aw_valid, lsu_aw_ready, lsu_w_valid, lsu_w_ready;
  logic  lsu_b_valid, lsu_b_ready, lsu_ar_valid, lsu_ar_ready, lsu_r_valid, lsu_r_ready;
  addr_t lsu_aw_addr, lsu_ar_addr;
  data_t lsu_w_data, lsu_r_data;
  strb_t lsu_w_strb;
  resp_t lsu_b_resp, lsu_r_resp;

  // arbiter to memory
  logic  s_aw_valid, s_aw_ready, s_w_valid, s_w_ready;
  logic  s_b_valid, s_b_ready, s_ar_valid, s_ar_ready, s_r_valid, s_r_ready;
  addr_t s_aw_addr, s_ar_addr;
  data_t s_w_data, s_r_data;
  strb_t s_w_strb;
  resp_t s_b_resp, s_r_resp;

  mem_access_bridge u_ifu_bridge (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (ifu_req_valid_i),  .req_ready_o (ifu_req_ready_o),
    .req_we_i    (ifu_req_we_i),     .req_addr_i  (ifu_req_addr_i),
    .req_type_i  (ifu_req_type_i),   .req_wdata_i (ifu_req_wdata_i),
    .resp_valid_o(ifu_resp_valid_o), .resp_data_o (ifu_resp_data_o),
    .resp_err_o  (ifu_resp_err_o),
    .aw_valid_o(ifu_aw_valid), .aw_ready_i(ifu_aw_ready), .aw_addr_o(ifu_aw_addr),
    .w_valid_o(ifu_w_valid), .w_ready_i(ifu_w_ready), .w_data_o(ifu_w_data),
    .w_strb_o(ifu_w_strb),
    .b_valid_i(ifu_b_valid), .b_ready_o(ifu_b_ready), .b_resp_i(ifu_b_resp),
    .ar_valid_o(ifu_ar_valid), .ar_ready_i(ifu_ar_ready), .ar_addr_o(ifu_ar_addr),
    .r_valid_i(ifu_r_valid), .r_ready_o(ifu_r_ready), .r_data_i(ifu_r_data),
    .r_resp_i(ifu_r_resp)
  );

  mem_access_bridge u_lsu_bridge (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (lsu_req_valid_i),  .req_ready_o (lsu_req_ready_o),
    .req_we_i    (lsu_req_we_i),     .req_addr_i  (lsu_req_addr_i),
    .req_type_i  (lsu_req_type_i),   .req_wdata_i (lsu_req_wdata_i),
    .resp_valid_o(lsu_resp_valid_o), .resp_data_o (lsu_resp_data_o),
    .resp_err_o  (lsu_resp_err_o),
    .aw_valid_o(lsu_aw_valid), .aw_ready_i(lsu_aw_ready), .aw_addr_o(lsu_aw_addr),
    .w_valid_o(lsu_w_valid), .w_ready_i(lsu_w_ready), .w_data_o(lsu_w_data),
    .w_strb_o(lsu_w_strb),
    .b_valid_i(lsu_b_valid), .b_ready_o(lsu_b_ready), .b_resp_i(lsu_b_resp),
    .ar_valid_o(lsu_ar_valid), .ar_ready_i(lsu_ar_ready), .ar_addr_o(lsu_ar_addr),
    .r_valid_i(lsu_r_valid), .r_ready_o(lsu_r_ready), .r_data_i(lsu_r_data),
    .r_resp_i(lsu_r_resp)
  );

  bus_arbiter u_arbiter (
    .clk(clk),
    .rst(rst),
    .m0_aw_valid_i(ifu_aw_valid), .m0_aw_ready_o(ifu_aw_ready), .m0_aw_addr_i(ifu_aw_addr),
    .m0_w_valid_i(ifu_w_valid), .m0_w_ready_o(ifu_w_ready), .m0_w_data_i(ifu_w_data),
    .m0_w_strb_i(ifu_w_strb),
    .m0_b_valid_o(ifu_b_valid), .m0_b_ready_i(ifu_b_ready), .m0_b_resp_o(ifu_b_resp),
    .m0_ar_valid_i(ifu_ar_valid), .m0_ar_ready_o(ifu_ar_ready), .m0_ar_addr_i(ifu_ar_addr),
    .m0_r_valid_o(ifu_r_valid), .m0_r_ready_i(ifu_r_ready), .m0_r_data_o(ifu_r_data),
    .m0_r_resp_o(ifu_r_resp),
    .m1_aw_valid_i(lsu_aw_valid), .m1_aw_ready_o(lsu_aw_ready), .m1_aw_addr_i(lsu_aw_addr),
    .m1_w_valid_i(lsu_w_valid), .m1_w_ready_o(lsu_w_ready), .m1_w_data_i(lsu_w_data),
    .m1_w_strb_i(lsu_w_strb),
    .m1_b_valid_o(lsu_b_valid), .m1_b_ready_i(lsu_b_ready), .m1_b_resp_o(lsu_b_resp),
    .m1_ar_valid_i(lsu_ar_valid), .m1_ar_ready_o(lsu_ar_ready), .m1_ar_addr_i(lsu_ar_addr),
    .m1_r_valid_o(lsu_r_valid), .m1_r_ready_i(lsu_r_ready), .m1_r_data_o(lsu_r_data),
    .m1_r_resp_o(lsu_r_resp),
    .s_aw_valid_o(s_aw_valid), .s_aw_ready_i(s_aw_ready), .s_aw_addr_o(s_aw_addr),
    .s_w_valid_o(s_w_valid), .s_w_ready_i(s_w_ready), .s_w_data_o(s_w_data),
    .s_w_strb_o(s_w_strb),
    .s_b_valid_i(s_b_valid), .s_b_ready_o(s_b_ready), .s_b_resp_i(s_b_resp),
    .s_ar_valid_o(s_ar_valid), .s_ar_ready_i(s_ar_ready), .s_ar_addr_o(s_ar_addr),
    .s_r_valid_i(s_r_valid), .s_r_ready_o(s_r_ready), .s_r_data_i(s_r_data),
    .s_r_resp_i(s_r_resp)
  );

  axi_mem_slave #(
    .mem_words(mem_words)
  ) u_mem (
    .clk(clk),
    .rst(rst),
    .aw_valid_i(s_aw_valid), .aw_ready_o(s_aw_ready), .aw_addr_i(s_aw_addr),
    .w_valid_i(s_w_valid), .w_ready_o(s_w_ready), .w_data_i(s_w_data),
    .w_strb_i(s_w_strb),
    .b_valid_o(s_b_valid), .b_ready_i(s_b_ready), .b_resp_o(s_b_resp),
    .ar_valid_i(s_ar_valid), .ar_ready_o(s_ar_ready), .ar_addr_i(s_ar_addr),
    .r_valid_o(s_r_valid), .r_ready_i(s_r_ready), .r_data_o(s_r_data),
    .r_resp_o(s_r_resp)
  );

endmodule

`default_nettype wire

// ==== dv/mem_bus_tb.sv ====
`default_nettype none

module mem_bus_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import mem_bus_pkg::*;

  localparam int mem_words   = 256;
  localparam int mem_bytes   = mem_words * 8;
  localparam int half_bytes  = mem_words * 4;
  localparam int n_dual      = 40;
  // request count of each test in run order
  localparam int n_requests  = 32 + 48 + 2 * n_dual + 16;
  localparam int cycle_limit = n_requests * 30 + 2000;
  localparam int wait_limit  = 400;

  logic    clk;
  logic    rst;
  logic    ifu_req_valid, ifu_req_ready, ifu_req_we;
  addr_t   ifu_req_addr;
  access_e ifu_req_type;
  data_t   ifu_req_wdata, ifu_resp_data;
  logic    ifu_resp_valid, ifu_resp_err;
  logic    lsu_req_valid, lsu_req_ready, lsu_req_we;
  addr_t   lsu_req_addr;
  access_e lsu_req_type;
  data_t   lsu_req_wdata, lsu_resp_data;
  logic    lsu_resp_valid, lsu_resp_err;

  // reference memory with one entry per byte
  logic [7:0] model [mem_bytes];
  int seed = 32'h511e_0f7d;
  int errors;
  int test_mark;
  int tests_passed;
  int tests_failed;
  int cycles;
  int resp_pulses [2];

  logic    dual_we    [2][n_dual];
  addr_t   dual_addr  [2][n_dual];
  access_e dual_kind  [2][n_dual];
  data_t   dual_wdata [2][n_dual];

  mem_bus_top #(
    .mem_words(mem_words)
  ) DUT (
    .clk(clk),
    .rst(rst),
    .ifu_req_valid_i(ifu_req_valid), .ifu_req_ready_o(ifu_req_ready),
    .ifu_req_we_i(ifu_req_we), .ifu_req_addr_i(ifu_req_addr),
    .ifu_req_type_i(ifu_req_type), .ifu_req_wdata_i(ifu_req_wdata),
    .ifu_resp_valid_o(ifu_resp_valid), .ifu_resp_data_o(ifu_resp_data),
    .ifu_resp_err_o(ifu_resp_err),
    .lsu_req_valid_i(lsu_req_valid), .lsu_req_ready_o(lsu_req_ready),
    .lsu_req_we_i(lsu_req_we), .lsu_req_addr_i(lsu_req_addr),
    .lsu_req_type_i(lsu_req_type), .lsu_req_wdata_i(lsu_req_wdata),
    .lsu_resp_valid_o(lsu_resp_valid), .lsu_resp_data_o(lsu_resp_data),
    .lsu_resp_err_o(lsu_resp_err)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // response pulses seen on each port
  always @(posedge clk) begin
    if (ifu_resp_valid === 1'b1) begin
      resp_pulses[0]++;
    end
    if (lsu_resp_valid === 1'b1) begin
      resp_pulses[1]++;
    end
  end

  function automatic int access_bytes(input access_e kind);
    case (kind)
      acc_b, acc_bu: return 1;
      acc_h, acc_hu: return 2;
      acc_w, acc_wu: return 4;
      default:       return 8;
    endcase
  endfunction

  function automatic bit is_signed(input access_e kind);
    return (kind == acc_b) || (kind == acc_h) || (kind == acc_w);
  endfunction

  // gather the bytes and extend from the top byte read
  function automatic data_t model_read(input addr_t addr, input access_e kind);
    data_t value;
    int    n;
    n = access_bytes(kind);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value[8*i +: 8] = model[int'(addr) + i];
    end
    if (n < 8 && is_signed(kind) && value[8*n-1]) begin
      value = value | (~64'd0 << (8 * n));
    end
    return value;
  endfunction

  function automatic void model_write(input addr_t addr, input access_e kind,
                                      input data_t wdata);
    for (int i = 0; i < access_bytes(kind); i++) begin
      model[int'(addr) + i] = wdata[8*i +: 8];
    end
  endfunction

  function automatic data_t rand_data();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic access_e rand_kind();
    int unsigned pick;
    pick = $unsigned($random(seed)) % 7;
    return access_e'(pick[2:0]);
  endfunction

  // aligned address inside the port's half of the memory
  function automatic addr_t rand_addr(input int port, input access_e kind);
    addr_t off;
    off = addr_t'($random(seed)) & addr_t'(half_bytes - 1);
    off = off & ~(addr_t'(access_bytes(kind)) - 32'd1);
    return (port == 1) ? addr_t'(half_bytes) + off : off;
  endfunction

  task automatic check_value(input string test_name, input string what,
                             input data_t expected, input data_t actual);
    if (expected !== actual) begin
      $display("ERROR %s %s: expected %h actual %h", test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic drive_req(input int port, input logic valid, input logic we,
                           input addr_t addr, input access_e kind, input data_t wdata);
    if (port == 1) begin
      lsu_req_valid <= valid;
      lsu_req_we    <= we;
      lsu_req_addr  <= addr;
      lsu_req_type  <= kind;
      lsu_req_wdata <= wdata;
    end else begin
      ifu_req_valid <= valid;
      ifu_req_we    <= we;
      ifu_req_addr  <= addr;
      ifu_req_type  <= kind;
      ifu_req_wdata <= wdata;
    end
  endtask

  // one request on one port with outputs sampled on the falling edge
  task automatic run_request(input int port, input logic we, input addr_t addr,
                             input access_e kind, input data_t wdata,
                             output data_t rdata, output logic rerr, output bit seen);
    int waited;
    seen = 1'b0;
    rdata = '0;
    rerr = 1'b0;
    @(posedge clk);
    drive_req(port, 1'b1, we, addr, kind, wdata);
    waited = 0;
    @(negedge clk);
    while (!((port == 1) ? lsu_req_ready : ifu_req_ready) && waited < wait_limit) begin
      @(negedge clk);
      waited++;
    end
    @(posedge clk);
    drive_req(port, 1'b0, 1'b0, '0, acc_d, '0);
    waited = 0;
    while (!seen && waited < wait_limit) begin
      @(negedge clk);
      waited++;
      if ((port == 1) ? lsu_resp_valid : ifu_resp_valid) begin
        seen = 1'b1;
        rdata = (port == 1) ? lsu_resp_data : ifu_resp_data;
        rerr = (port == 1) ? lsu_resp_err : ifu_resp_err;
      end
    end
  endtask

  // expected values come from the model before it is updated
  task automatic access(input int port, input logic we, input addr_t addr,
                        input access_e kind, input data_t wdata, input string test_name);
    logic  exp_err;
    data_t exp_data;
    data_t got_data;
    logic  got_err;
    bit    seen;
    exp_err = (addr >= addr_t'(mem_bytes));
    exp_data = (we || exp_err) ? '0 : model_read(addr, kind);
    run_request(port, we, addr, kind, wdata, got_data, got_err, seen);
    if (!seen) begin
      $display("%s: no response on the %s port for address %h within %0d cycles",
               test_name, (port == 1) ? "lsu" : "ifu", addr, wait_limit);
      errors++;
    end else begin
      check_value(test_name, "resp_err", {63'd0, exp_err}, {63'd0, got_err});
      check_value(test_name, "resp_data", exp_data, got_data);
    end
    if (we && !exp_err) begin
      model_write(addr, kind, wdata);
    end
  endtask

  task automatic start_test();
    test_mark = errors;
  endtask

  task automatic report_test(input string test_name);
    if (errors == test_mark) begin
      $display("test %s: passed", test_name);
      tests_passed++;
    end else begin
      $display("test %s: failed with %0d errors", test_name, errors - test_mark);
      tests_failed++;
    end
  endtask

  task automatic idle_after_reset();
    int pulses;
    start_test();
    pulses = 0;
    @(negedge clk);
    check_value("reset", "ifu req_ready", 64'd1, {63'd0, ifu_req_ready});
    check_value("reset", "lsu req_ready", 64'd1, {63'd0, lsu_req_ready});
    repeat (20) begin
      @(negedge clk);
      if (ifu_resp_valid || lsu_resp_valid) begin
        pulses++;
      end
    end
    check_value("reset", "response pulses", 64'd0, 64'(pulses));
    report_test("reset");
  endtask

  task automatic write_each_size();
    access_e sizes [4];
    addr_t   addr;
    sizes = '{acc_b, acc_h, acc_w, acc_d};
    start_test();
    foreach (sizes[s]) begin
      repeat (4) begin
        addr = rand_addr(0, sizes[s]);
        access(0, 1'b1, addr, sizes[s], rand_data(), "write_sizes");
        access(0, 1'b0, addr & ~addr_t'(7), acc_d, '0, "write_sizes");
      end
    end
    report_test("write_sizes");
  endtask

  task automatic read_each_type();
    addr_t   base;
    addr_t   off;
    access_e kind;
    start_test();
    repeat (6) begin
      base = rand_addr(1, acc_d);
      access(1, 1'b1, base, acc_d, rand_data(), "read_types");
      for (int k = 0; k < 7; k++) begin
        kind = access_e'(3'(k));
        off = addr_t'($random(seed)) & 32'h7 & ~(addr_t'(access_bytes(kind)) - 32'd1);
        access(1, 1'b0, base + off, kind, '0, "read_types");
      end
    end
    report_test("read_types");
  endtask

  task automatic run_stream(input int port);
    for (int i = 0; i < n_dual; i++) begin
      access(port, dual_we[port][i], dual_addr[port][i], dual_kind[port][i],
             dual_wdata[port][i], "dual_port");
    end
  endtask

  // stimulus drawn up front so both streams are fixed by the seed
  task automatic dual_port_traffic();
    int pulses_before [2];
    start_test();
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < n_dual; i++) begin
        dual_we[p][i] = $random(seed) & 1;
        dual_kind[p][i] = rand_kind();
        dual_addr[p][i] = rand_addr(p, dual_kind[p][i]);
        dual_wdata[p][i] = rand_data();
      end
    end
    // the last pulse of the previous test is counted one edge after it was seen
    @(negedge clk);
    pulses_before[0] = resp_pulses[0];
    pulses_before[1] = resp_pulses[1];
    fork
      run_stream(0);
      run_stream(1);
    join
    // a repeated pulse would follow one cycle after the last response
    repeat (2) @(negedge clk);
    for (int p = 0; p < 2; p++) begin
      check_value("dual_port", (p == 1) ? "lsu response count" : "ifu response count",
                  64'(n_dual), 64'(resp_pulses[p] - pulses_before[p]));
    end
    report_test("dual_port");
  endtask

  // the out of range address aliases base in the word index bits
  task automatic out_of_range_access();
    addr_t base;
    start_test();
    repeat (4) begin
      base = rand_addr(1, acc_d);
      access(1, 1'b1, base, acc_d, rand_data(), "out_of_range");
      access(1, 1'b1, base + addr_t'(mem_bytes), acc_d, rand_data(), "out_of_range");
      access(1, 1'b0, base + addr_t'(mem_bytes), rand_kind(), '0, "out_of_range");
      access(1, 1'b0, base, acc_d, '0, "out_of_range");
    end
    report_test("out_of_range");
  endtask

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("Test failed");
    $finish;
  end

  initial begin
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    resp_pulses[0] = 0;
    resp_pulses[1] = 0;
    rst = 1'b1;
    ifu_req_valid = 1'b0;
    ifu_req_we = 1'b0;
    ifu_req_addr = '0;
    ifu_req_type = acc_d;
    ifu_req_wdata = '0;
    lsu_req_valid = 1'b0;
    lsu_req_we = 1'b0;
    lsu_req_addr = '0;
    lsu_req_type = acc_d;
    lsu_req_wdata = '0;
    foreach (model[i]) begin
      model[i] = 8'h00;
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    idle_after_reset();
    write_each_size();
    read_each_type();
    dual_port_traffic();
    out_of_range_access();
    $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mem_bus_top.f ====
source/mem_bus_pkg.sv
source/mem_access_bridge.sv
source/bus_arbiter.sv
source/axi_mem_slave.sv
source/mem_bus_top.sv
dv/mem_bus_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the Verilator model, run it and look for the pass message in its output
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module mem_bus_tb \
    -f mem_bus_top.f -o mem_bus_sim &&
  ./obj_dir/mem_bus_sim | tee /dev/stderr | grep -q "Test completed successfully" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
